// File: common/poly_pkg.sv
// shared widths and token formats; unsigned arithmetic only, spare command bits are ignored
`default_nettype none

package poly_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int data_w   = 16;           // coefficient and x tokens
    localparam int result_w = 32;           // horner result, mod 2^32
    localparam int count_w  = 6;            // command count field

    // ------------------------------------------------------------
    // opcodes and status codes
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        op_stp = 2'd0,                      // load coefficients
        op_evp = 2'd1,                      // evaluate a block of x
        op_bad = 2'd2,                      // reserved, old block-evaluate slot
        op_rst = 2'd3                       // forget the polynomial
    } poly_op_e;

    typedef enum logic [1:0] {
        st_ok        = 2'd0,
        st_no_poly   = 2'd1,                // evp with nothing loaded
        st_bad_count = 2'd2,                // zero count or too many terms
        st_bad_op    = 2'd3
    } poly_status_e;

    // ------------------------------------------------------------
    // stream tokens
    // ------------------------------------------------------------
    // command word, opcode in the top bits
    typedef struct packed {
        poly_op_e             opcode;
        logic [count_w-1:0]   count;
        logic [7:0]           spare;        // don't care
    } poly_cmd_t;

    typedef struct packed {
        logic [result_w-1:0]  value;
        poly_status_e         status;
    } poly_result_t;

endpackage

`default_nettype wire

// File: logic/poly_actor_top.sv
// polynomial actor top; max_terms 2..32, fifo_depth a power of two, result latency varies
`default_nettype none
`timescale 1ns/1ps

module poly_actor_top #(
    parameter int max_terms  = 8,
    parameter int fifo_depth = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  poly_pkg::poly_cmd_t            cmd_token,
    input  logic                           data_valid,
    output logic                           data_ready,
    input  logic [poly_pkg::data_w-1:0]    data_token,
    output logic                           out_valid,
    input  logic                           out_ready,
    output poly_pkg::poly_result_t         out_token
);

    localparam int idx_w  = $clog2(max_terms);
    localparam int term_w = $clog2(max_terms + 1);
    localparam int cmd_w  = $bits(poly_pkg::poly_cmd_t);

    logic                           cmd_head_valid;
    logic                           cmd_head_ready;
    poly_pkg::poly_cmd_t            cmd_head;
    logic                           data_head_valid;
    logic                           data_head_ready;
    logic [poly_pkg::data_w-1:0]    data_head;
    logic                           coef_wr;
    logic [idx_w-1:0]               coef_idx;
    logic [poly_pkg::data_w-1:0]    coef_data;
    logic                           eval_start;
    logic [poly_pkg::data_w-1:0]    eval_x;
    logic [term_w-1:0]              eval_terms;
    logic                           eval_done;
    logic [poly_pkg::result_w-1:0]  eval_value;
    logic                           res_valid;
    logic                           res_ready;
    poly_pkg::poly_result_t         res_token;

    // ------------------------------------------------------------
    // input side
    // ------------------------------------------------------------
    token_fifo #(.width(cmd_w), .fifo_depth(fifo_depth)) cmd_fifo (
        .clk(clk), .rst(rst),
        .in_valid(cmd_valid), .in_ready(cmd_ready), .in_data(cmd_token),
        .out_valid(cmd_head_valid), .out_ready(cmd_head_ready), .out_data(cmd_head)
    );

    token_fifo #(.width(poly_pkg::data_w), .fifo_depth(fifo_depth)) data_fifo (
        .clk(clk), .rst(rst),
        .in_valid(data_valid), .in_ready(data_ready), .in_data(data_token),
        .out_valid(data_head_valid), .out_ready(data_head_ready), .out_data(data_head)
    );

    // ------------------------------------------------------------
    // engine and output side
    // ------------------------------------------------------------
    firing_controller #(.max_terms(max_terms)) u_ctrl (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_head_valid), .cmd_ready(cmd_head_ready), .cmd_token(cmd_head),
        .data_valid(data_head_valid), .data_ready(data_head_ready), .data_token(data_head),
        .coef_wr(coef_wr), .coef_idx(coef_idx), .coef_data(coef_data),
        .eval_start(eval_start), .eval_x(eval_x), .eval_terms(eval_terms),
        .eval_done(eval_done), .eval_value(eval_value),
        .res_valid(res_valid), .res_ready(res_ready), .res_token(res_token)
    );

    horner_eval #(.max_terms(max_terms)) u_horner (
        .clk(clk), .rst(rst),
        .coef_wr(coef_wr), .coef_idx(coef_idx), .coef_data(coef_data),
        .eval_start(eval_start), .eval_x(eval_x), .eval_terms(eval_terms),
        .eval_done(eval_done), .eval_value(eval_value)
    );

    result_emitter u_emit (
        .clk(clk), .rst(rst),
        .res_valid(res_valid), .res_ready(res_ready), .res_token(res_token),
        .out_valid(out_valid), .out_ready(out_ready), .out_token(out_token)
    );

endmodule

`default_nettype wire

// File: logic/result_emitter.sv
// one-slot output register; res_ready depends combinationally on out_ready
`default_nettype none
`timescale 1ns/1ps

module result_emitter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    res_valid,
    output logic                    res_ready,
    input  poly_pkg::poly_result_t  res_token,
    output logic                    out_valid,
    input  logic                    out_ready,
    output poly_pkg::poly_result_t  out_token
);

    logic load_slot;

    assign res_ready = !out_valid || out_ready;     // empty, or emptied this cycle
    assign load_slot = res_valid && res_ready;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            out_valid <= 1'b0;
        else if (load_slot)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (load_slot)
            out_token <= res_token;                 // held steady until taken
    end

endmodule

`default_nettype wire

// File: logic/token_fifo.sv
// register FIFO with valid/ready on both sides; fifo_depth must be a power of two, at least 2
`default_nettype none
`timescale 1ns/1ps

module token_fifo #(
    parameter int width      = 16,
    parameter int fifo_depth = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [width-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [width-1:0] out_data
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = ptr_w + 1;

    logic [width-1:0] mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];                 // head is already registered
    // when full, a pop in the same cycle frees the slot
    assign in_ready  = (count != cnt_w'(fifo_depth)) || out_ready;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // ------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;            // wraps, depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

`default_nettype wire

// File: poly_actor_top.f
common/poly_pkg.sv
logic/token_fifo.sv
logic/result_emitter.sv
poly_engine/horner_eval.sv
poly_engine/firing_controller.sv
logic/poly_actor_top.sv
testbench/tb_poly_actor.sv

// File: poly_engine/firing_controller.sv
// command FSM; runs one command at a time, validates it, and owns all status decisions
`default_nettype none
`timescale 1ns/1ps

module firing_controller #(
    parameter int max_terms = 8
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cmd_valid,
    output logic                               cmd_ready,
    input  poly_pkg::poly_cmd_t                cmd_token,
    input  logic                               data_valid,
    output logic                               data_ready,
    input  logic [poly_pkg::data_w-1:0]        data_token,
    output logic                               coef_wr,
    output logic [$clog2(max_terms)-1:0]       coef_idx,
    output logic [poly_pkg::data_w-1:0]        coef_data,
    output logic                               eval_start,
    output logic [poly_pkg::data_w-1:0]        eval_x,
    output logic [$clog2(max_terms+1)-1:0]     eval_terms,
    input  logic                               eval_done,
    input  logic [poly_pkg::result_w-1:0]      eval_value,
    output logic                               res_valid,
    input  logic                               res_ready,
    output poly_pkg::poly_result_t             res_token
);

    localparam int idx_w  = $clog2(max_terms);
    localparam int term_w = $clog2(max_terms + 1);

    typedef enum logic [2:0] {idle, decode, load, eval_fetch, eval_wait, emit, done} state_e;

    state_e                         state;
    state_e                         state_nx;
    poly_pkg::poly_cmd_t            cmd_reg;
    logic [poly_pkg::count_w-1:0]   remaining;      // data tokens still to pop
    logic                           loaded;
    logic [term_w-1:0]              terms;          // size of the loaded polynomial
    logic [idx_w-1:0]               load_idx;
    poly_pkg::poly_result_t         res_reg;
    poly_pkg::poly_status_e         decode_status;
    logic                           stp_count_ok;
    logic                           data_fire;

    assign cmd_ready  = (state == idle);
    assign data_ready = (state == load) || (state == eval_fetch);
    assign data_fire  = data_valid && data_ready;

    assign coef_wr    = (state == load) && data_valid;
    assign coef_idx   = load_idx;
    assign coef_data  = data_token;
    assign eval_start = (state == eval_fetch) && data_valid && loaded;
    assign eval_x     = data_token;
    assign eval_terms = terms;
    assign res_valid  = (state == emit);
    assign res_token  = res_reg;

    assign stp_count_ok = (cmd_reg.count != '0) && (cmd_reg.count <= max_terms);

    always_comb
    begin
        case (cmd_reg.opcode)
            poly_pkg::op_stp: decode_status = stp_count_ok ? poly_pkg::st_ok
                                                           : poly_pkg::st_bad_count;
            poly_pkg::op_evp: decode_status = (cmd_reg.count != '0) ? poly_pkg::st_ok
                                                                    : poly_pkg::st_bad_count;
            poly_pkg::op_bad: decode_status = poly_pkg::st_bad_op;
            default:          decode_status = poly_pkg::st_ok;
        endcase
    end

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------
    always_comb
    begin
        state_nx = state;
        case (state)
            idle:       if (cmd_valid) state_nx = decode;
            decode:
            begin
                case (cmd_reg.opcode)
                    poly_pkg::op_stp: state_nx = stp_count_ok ? load : emit;
                    poly_pkg::op_evp: state_nx = (cmd_reg.count != '0) ? eval_fetch : emit;
                    poly_pkg::op_rst: state_nx = done;   // silent
                    default:          state_nx = emit;
                endcase
            end
            load:       if (data_valid && remaining == 1) state_nx = emit;
            eval_fetch: if (data_valid) state_nx = loaded ? eval_wait : emit;
            eval_wait:  if (eval_done) state_nx = emit;
            emit:       if (res_ready) state_nx = (remaining != '0) ? eval_fetch : done;
            default:    state_nx = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state     <= idle;
            remaining <= '0;
            loaded    <= 1'b0;
            terms     <= '0;
        end
        else
        begin
            state <= state_nx;
            if (state == decode)
            begin
                if (cmd_reg.opcode == poly_pkg::op_rst)
                    loaded <= 1'b0;
                if (decode_status == poly_pkg::st_ok && cmd_reg.opcode != poly_pkg::op_rst)
                    remaining <= cmd_reg.count;
                else
                    remaining <= '0;                 // error path emits once
            end
            else if (data_fire)
            begin
                remaining <= remaining - 1'b1;
                if (state == load && remaining == 1)
                begin
                    loaded <= 1'b1;
                    terms  <= term_w'(cmd_reg.count);
                end
            end
        end
    end

    // payload registers
    always_ff @(posedge clk)
    begin
        if (cmd_valid && cmd_ready)
            cmd_reg <= cmd_token;
        case (state)
            decode:
            begin
                load_idx <= idx_w'(cmd_reg.count - 1'b1);   // first token is highest order
                res_reg  <= '{value: '0, status: decode_status};
            end
            load:
                if (data_fire)
                begin
                    load_idx <= load_idx - 1'b1;
                    res_reg  <= '{value: poly_pkg::result_w'(cmd_reg.count),
                                  status: poly_pkg::st_ok};
                end
            eval_fetch:
                if (data_fire && !loaded)
                    res_reg <= '{value: '0, status: poly_pkg::st_no_poly};
            eval_wait:
                if (eval_done)
                    res_reg <= '{value: eval_value, status: poly_pkg::st_ok};
            default:
                ;
        endcase
    end

endmodule

`default_nettype wire

// File: poly_engine/horner_eval.sv
// coefficient store and serial horner evaluator; eval_terms must be 1..max_terms, no writes while busy
`default_nettype none
`timescale 1ns/1ps

module horner_eval #(
    parameter int max_terms = 8
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               coef_wr,
    input  logic [$clog2(max_terms)-1:0]       coef_idx,
    input  logic [poly_pkg::data_w-1:0]        coef_data,
    input  logic                               eval_start,
    input  logic [poly_pkg::data_w-1:0]        eval_x,
    input  logic [$clog2(max_terms+1)-1:0]     eval_terms,
    output logic                               eval_done,
    output logic [poly_pkg::result_w-1:0]      eval_value
);

    localparam int idx_w  = $clog2(max_terms);
    localparam int term_w = $clog2(max_terms + 1);

    logic [poly_pkg::data_w-1:0]    coef_mem [max_terms];
    logic [poly_pkg::result_w-1:0]  acc;
    logic [poly_pkg::data_w-1:0]    x_reg;
    logic [idx_w-1:0]               idx;            // next coefficient to fold in
    logic [term_w-1:0]              steps_left;
    logic                           busy;
    logic [idx_w-1:0]               top_idx;

    assign top_idx    = idx_w'(eval_terms - 1'b1);
    assign eval_value = acc;

    always_ff @(posedge clk)
    begin
        if (coef_wr)
            coef_mem[coef_idx] <= coef_data;
    end

    // ------------------------------------------------------------
    // sequencing
    // ------------------------------------------------------------
    // the start cycle folds in the top coefficient, so n terms take n cycles
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            busy       <= 1'b0;
            steps_left <= '0;
            eval_done  <= 1'b0;
        end
        else
        begin
            eval_done <= 1'b0;
            if (eval_start)
            begin
                steps_left <= eval_terms - 1'b1;
                busy       <= (eval_terms > 1);
                eval_done  <= (eval_terms == 1);
            end
            else if (busy)
            begin
                steps_left <= steps_left - 1'b1;
                if (steps_left == 1)
                begin
                    busy      <= 1'b0;
                    eval_done <= 1'b1;
                end
            end
        end
    end

    // datapath, 32x16 multiply-add truncated to 32 bits
    always_ff @(posedge clk)
    begin
        if (eval_start)
        begin
            acc   <= poly_pkg::result_w'(coef_mem[top_idx]);
            x_reg <= eval_x;
            idx   <= top_idx - 1'b1;
        end
        else if (busy)
        begin
            acc <= acc * poly_pkg::result_w'(x_reg) + poly_pkg::result_w'(coef_mem[idx]);
            idx <= idx - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the polynomial actor testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_poly_actor -f poly_actor_top.f -o tb_poly_actor_sim

./obj_dir/tb_poly_actor_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
exit 0

// File: testbench/tb_poly_actor.sv
// testbench for poly_actor_top at max_terms 8, fifo_depth 4; needs a simulator with timing and assertions on
`default_nettype none
`timescale 1ns/1ps

module tb_poly_actor;

    localparam int max_terms  = 8;
    localparam int fifo_depth = 4;
    localparam int wait_limit = 2000;               // cycles per wait loop

    typedef logic [poly_pkg::data_w-1:0] word_t;

    logic                    clk;
    logic                    rst;
    logic                    cmd_valid;
    logic                    cmd_ready;
    poly_pkg::poly_cmd_t     cmd_token;
    logic                    data_valid;
    logic                    data_ready;
    word_t                   data_token;
    logic                    out_valid;
    logic                    out_ready;
    poly_pkg::poly_result_t  out_token;

    poly_pkg::poly_cmd_t     cmd_stim_q [$];
    word_t                   data_stim_q [$];
    poly_pkg::poly_result_t  exp_q [$];
    word_t                   model_coef [$];        // highest order first
    logic                    model_loaded = 1'b0;
    int                      stretch_tab [32];
    int                      ready_mode = 0;        // 0 ready, 1 random stretches, 2 held low
    int                      value_errs = 0;
    int                      status_errs = 0;
    int                      flow_errs = 0;
    logic                    hold_prev = 1'b0;
    poly_pkg::poly_result_t  token_prev;
    logic                    saw_cmd_full = 1'b0;
    logic                    saw_data_full = 1'b0;

    poly_actor_top #(.max_terms(max_terms), .fifo_depth(fifo_depth)) DUT (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_token(cmd_token),
        .data_valid(data_valid), .data_ready(data_ready), .data_token(data_token),
        .out_valid(out_valid), .out_ready(out_ready), .out_token(out_token)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] horner_ref(input word_t x);
        logic [31:0] acc;
        acc = '0;
        foreach (model_coef[i])
            acc = acc * 32'(x) + 32'(model_coef[i]);   // wraps mod 2^32
        return acc;
    endfunction

    task automatic expect_token(input logic [31:0] value, input poly_pkg::poly_status_e st);
        poly_pkg::poly_result_t res;
        res.value  = value;
        res.status = st;
        exp_q.push_back(res);
    endtask

    // queue one command with its data and the results it should produce
    task automatic issue(input poly_pkg::poly_op_e op, input int count);
        poly_pkg::poly_cmd_t cmd;
        word_t               w;
        cmd.opcode = op;
        cmd.count  = 6'(count);
        cmd.spare  = 8'($urandom);                  // ignored by the DUT
        cmd_stim_q.push_back(cmd);
        case (op)
            poly_pkg::op_stp:
                if (count == 0 || count > max_terms)
                    expect_token(32'd0, poly_pkg::st_bad_count);
                else
                begin
                    model_coef.delete();
                    for (int i = 0; i < count; i++)
                    begin
                        w = word_t'($urandom);
                        model_coef.push_back(w);
                        data_stim_q.push_back(w);
                    end
                    model_loaded = 1'b1;
                    expect_token(32'(count), poly_pkg::st_ok);
                end
            poly_pkg::op_evp:
                if (count == 0)
                    expect_token(32'd0, poly_pkg::st_bad_count);
                else
                    for (int i = 0; i < count; i++)
                    begin
                        w = word_t'($urandom);
                        data_stim_q.push_back(w);
                        if (model_loaded)
                            expect_token(horner_ref(w), poly_pkg::st_ok);
                        else
                            expect_token(32'd0, poly_pkg::st_no_poly);
                    end
            poly_pkg::op_rst:
                model_loaded = 1'b0;                // silent
            default:
                expect_token(32'd0, poly_pkg::st_bad_op);
        endcase
    endtask

    // ------------------------------------------------------------
    // checks and run control
    // ------------------------------------------------------------
    task automatic finish_run();
        $display("errors: value %0d, status %0d, other %0d", value_errs, status_errs, flow_errs);
        if (value_errs + status_errs + flow_errs == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        assert (got === want)
        else
        begin
            $display("error %0t %s expected %b got %b", $time, name, want, got);
            flow_errs++;
        end
    endtask

    task automatic check_output(input poly_pkg::poly_result_t got);
        poly_pkg::poly_result_t want;
        assert (exp_q.size() != 0)
        else
        begin
            $display("output token %h arrived at %0t with nothing expected", got, $time);
            flow_errs++;
        end
        if (exp_q.size() != 0)
        begin
            want = exp_q.pop_front();
            assert (got.value == want.value)
            else
            begin
                $display("error %0t out_token.value expected %h got %h",
                         $time, want.value, got.value);
                value_errs++;
            end
            assert (got.status == want.status)
            else
            begin
                $display("error %0t out_token.status expected %s got %s",
                         $time, want.status.name(), got.status.name());
                status_errs++;
            end
        end
    endtask

    function automatic logic work_pending();
        return exp_q.size() != 0 || cmd_stim_q.size() != 0 || data_stim_q.size() != 0
               || out_valid;
    endfunction

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (work_pending() && n < wait_limit)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (work_pending())
        begin
            $display("timeout while draining %s, %0d results still missing", what, exp_q.size());
            flow_errs++;
            finish_run();
        end
    endtask

    // values sampled at the edge are the ones held through the cycle
    always @(posedge clk)
    begin
        if (rst)
        begin
            if (hold_prev)
            begin
                assert (out_valid && out_token == token_prev)
                else
                begin
                    $display("error %0t out_token expected %h got %h (valid %b) during stall",
                             $time, token_prev, out_token, out_valid);
                    flow_errs++;
                end
            end
            if (out_valid && out_ready)
                check_output(out_token);
            hold_prev  = out_valid && !out_ready;
            token_prev = out_token;
            if (!cmd_ready)
                saw_cmd_full = 1'b1;
            if (!data_ready)
                saw_data_full = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // stream drivers
    // ------------------------------------------------------------
    initial
    begin
        int n;
        cmd_token = '0;
        forever
        begin
            if (cmd_stim_q.size() == 0)
            begin
                cmd_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            else
            begin
                cmd_valid = 1'b1;
                cmd_token = cmd_stim_q.pop_front();
                n = 0;
                #1;                                 // ready is settled here
                while (!cmd_ready && n < wait_limit)
                begin
                    @(posedge clk);
                    #2;
                    n++;
                end
                if (!cmd_ready)
                begin
                    $display("timeout, command stream never became ready");
                    flow_errs++;
                    finish_run();
                end
                @(posedge clk);
                #1;
            end
        end
    end

    initial
    begin
        int n;
        data_token = '0;
        forever
        begin
            if (data_stim_q.size() == 0)
            begin
                data_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            else
            begin
                data_valid = 1'b1;
                data_token = data_stim_q.pop_front();
                n = 0;
                #1;
                while (!data_ready && n < wait_limit)
                begin
                    @(posedge clk);
                    #2;
                    n++;
                end
                if (!data_ready)
                begin
                    $display("timeout, data stream never became ready");
                    flow_errs++;
                    finish_run();
                end
                @(posedge clk);
                #1;
            end
        end
    end

    initial
    begin
        int stretch;
        int tab_idx;
        stretch   = 0;
        tab_idx   = 0;
        out_ready = 1'b1;
        forever
        begin
            @(posedge clk);
            #1;
            if (ready_mode == 0)
                out_ready = 1'b1;
            else if (ready_mode == 2)
                out_ready = 1'b0;
            else if (stretch == 0)
            begin
                out_ready = !out_ready;
                stretch   = stretch_tab[tab_idx];
                tab_idx   = (tab_idx + 1) % 32;
            end
            else
                stretch--;
        end
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial
    begin
        int n;
        void'($urandom(32'h5671_cfbc));
        foreach (stretch_tab[i])
            stretch_tab[i] = $urandom_range(7, 1);
        rst = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("cmd_ready", cmd_ready, 1'b1);
        check_flag("data_ready", data_ready, 1'b1);
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        @(posedge clk);
        #2;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("cmd_ready", cmd_ready, 1'b1);
        check_flag("data_ready", data_ready, 1'b1);

        issue(poly_pkg::op_evp, 2);                 // nothing loaded yet
        issue(poly_pkg::op_stp, 5);
        issue(poly_pkg::op_evp, 6);
        wait_drained("load and evaluate");

        issue(poly_pkg::op_stp, 0);
        issue(poly_pkg::op_stp, 9);
        issue(poly_pkg::op_bad, 3);
        issue(poly_pkg::op_evp, 0);
        issue(poly_pkg::op_evp, 3);                 // old polynomial still loaded
        issue(poly_pkg::op_rst, 0);
        issue(poly_pkg::op_evp, 2);
        issue(poly_pkg::op_stp, 1);
        issue(poly_pkg::op_evp, 2);
        issue(poly_pkg::op_stp, max_terms);
        issue(poly_pkg::op_evp, 4);
        wait_drained("illegal requests and reset command");

        ready_mode = 1;
        for (int i = 0; i < 12; i++)
        begin
            if ($urandom_range(1, 0) == 0)
                issue(poly_pkg::op_stp, $urandom_range(max_terms, 1));
            else
                issue(poly_pkg::op_evp, $urandom_range(5, 1));
        end
        wait_drained("back-pressure");
        ready_mode = 0;

        saw_cmd_full  = 1'b0;
        saw_data_full = 1'b0;
        ready_mode    = 2;
        for (int i = 0; i < 6; i++)
            issue(poly_pkg::op_evp, 3);
        n = 0;
        while (!(saw_cmd_full && saw_data_full) && n < 300)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!(saw_cmd_full && saw_data_full))
        begin
            $display("input ready did not drop while outputs were held, cmd %b data %b",
                     saw_cmd_full, saw_data_full);
            flow_errs++;
        end
        ready_mode = 0;
        wait_drained("input flow control");

        finish_run();
    end

endmodule

`default_nettype wire
